//--- rtl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // One byte of instruction memory.
    typedef logic [7:0] byte_t;

    // Byte address as the core sees it.
    // The RAM decodes only its low address bits, so addresses wrap around the RAM size.
    typedef logic [31:0] addr_t;

    // One assembled instruction word, most significant byte from the lowest address.
    typedef logic [31:0] inst_t;

    // Fetch controller states, one per cycle of the six-cycle fetch.
    // FS_B3 to FS_B0 are named after the instruction byte that arrives in that state.
    typedef enum logic [2:0] {
        FS_ISSUE = 3'd0,
        FS_WAIT  = 3'd1,
        FS_B3    = 3'd2,
        FS_B2    = 3'd3,
        FS_B1    = 3'd4,
        FS_B0    = 3'd5
    } fetch_state_t;

endpackage

`default_nettype wire

//--- rtl/fetch_if.sv
`timescale 1ns/1ps
`default_nettype none

// Link between the program counter and the fetch controller.
// All signals belong to the clk domain.
interface fetch_if;

    import fetch_pkg::*;

    // High in the cycle in which the controller takes a new fetch address.
    logic  start;

    // Address of the next instruction to fetch, owned by the program counter.
    addr_t fetch_addr;

    // One-cycle pulse that marks inst and inst_addr as valid.
    logic  done;

    // Delivered instruction and its address.
    // Both hold their values until the next done.
    inst_t inst;
    addr_t inst_addr;

    // Fetch controller side.
    modport ctrl (
        output start,
        output done,
        output inst,
        output inst_addr,
        input  fetch_addr
    );

    // Program counter side.
    modport pc (
        output fetch_addr,
        input  start
    );

endinterface

`default_nettype wire

//--- rtl/pc_reg.sv
`timescale 1ns/1ps
`default_nettype none

// Program counter for the fetch subsystem.
// It offers the next fetch address and advances it whenever the controller
// starts a fetch. A redirect is held pending until that next start.
module pc_reg #(
    parameter fetch_pkg::addr_t RESET_PC = '0
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             redirect,
    input  fetch_pkg::addr_t redirect_target,
    fetch_if.pc              fif
);

    import fetch_pkg::*;

    // Pending redirect, kept until the next start consumes it.
    logic  pend_valid;
    addr_t pend_target;

    // Fetch address and pending flag.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fif.fetch_addr <= RESET_PC;
            pend_valid     <= 1'b0;
        end else begin
            if (fif.start) begin
                // The controller takes fetch_addr at this edge, so move on to the next one.
                // A redirect in this same cycle beats an older pending target.
                if (redirect) begin
                    fif.fetch_addr <= redirect_target;
                end else if (pend_valid) begin
                    fif.fetch_addr <= pend_target;
                end else begin
                    fif.fetch_addr <= fif.fetch_addr + 32'd4;
                end
                // The redirect is used up by this start in every case.
                pend_valid <= 1'b0;
            end else if (redirect) begin
                // Between starts the redirect waits for the next one.
                pend_valid <= 1'b1;
            end
        end
    end

    // Target of the latest redirect.
    // A later redirect simply overwrites an earlier one.
    // The value only matters while pend_valid is set.
    always_ff @(posedge clk) begin
        if (redirect) begin
            pend_target <= redirect_target;
        end
    end

endmodule

`default_nettype wire

//--- rtl/mem_control.sv
`timescale 1ns/1ps
`default_nettype none

// Byte-serial instruction fetch controller.
// Each fetch takes six cycles. The controller takes the address, reads four bytes
// from the byte RAM, one per cycle, and packs them most significant byte first.
// Then it delivers the word with a one-cycle done pulse.
module mem_control (
    input  logic             clk,
    input  logic             rst_n,
    output fetch_pkg::addr_t ram_addr,
    input  fetch_pkg::byte_t ram_rdata,
    fetch_if.ctrl            fif
);

    import fetch_pkg::*;

    fetch_state_t state;

    // Address of the instruction being fetched.
    addr_t base_addr;

    // Upper three bytes of the word being assembled.
    // The last byte goes straight from the RAM into inst.
    logic [31:8] asm_hi;

    // Start is decoded from the state, so the first cycle after reset already issues.
    assign fif.start = (state == FS_ISSUE);

    // State sequence and delivered outputs.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state         <= FS_ISSUE;
            fif.done      <= 1'b0;
            fif.inst      <= '0;
            fif.inst_addr <= '0;
        end else begin
            // Done is a single-cycle pulse unless FS_B0 sets it below.
            fif.done <= 1'b0;
            case (state)
                FS_ISSUE: begin
                    state <= FS_WAIT;
                end
                FS_WAIT: begin
                    state <= FS_B3;
                end
                FS_B3: begin
                    state <= FS_B2;
                end
                FS_B2: begin
                    state <= FS_B1;
                end
                FS_B1: begin
                    state <= FS_B0;
                end
                FS_B0: begin
                    // The lowest byte arrives now, so the word is complete.
                    // inst changes only here, which keeps it stable during the next fetch.
                    fif.inst      <= {asm_hi, ram_rdata};
                    fif.inst_addr <= base_addr;
                    fif.done      <= 1'b1;
                    state         <= FS_ISSUE;
                end
                default: begin
                    state <= FS_ISSUE;
                end
            endcase
        end
    end

    // Address sequencing and byte capture.
    // The RAM read is registered, so each byte comes back two states after
    // its address is loaded into ram_addr.
    always_ff @(posedge clk) begin
        case (state)
            FS_ISSUE: begin
                // Take the address from the program counter and begin at byte 0.
                base_addr <= fif.fetch_addr;
                ram_addr  <= fif.fetch_addr;
            end
            FS_WAIT: begin
                ram_addr <= base_addr + 32'd1;
            end
            FS_B3: begin
                // Byte at the lowest address.
                asm_hi[31:24] <= ram_rdata;
                ram_addr      <= base_addr + 32'd2;
            end
            FS_B2: begin
                asm_hi[23:16] <= ram_rdata;
                ram_addr      <= base_addr + 32'd3;
            end
            FS_B1: begin
                asm_hi[15:8] <= ram_rdata;
            end
            default: begin
                // FS_B0 waits for the last byte that is already in flight.
                ram_addr <= ram_addr;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/byte_ram.sv
`timescale 1ns/1ps
`default_nettype none

// Synchronous byte-wide instruction RAM.
// It has one registered read port for fetching and one write port for loading programs.
module byte_ram #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic             clk,
    input  fetch_pkg::addr_t rd_addr,
    output fetch_pkg::byte_t rd_data,
    input  logic             wr_en,
    input  fetch_pkg::addr_t wr_addr,
    input  fetch_pkg::byte_t wr_data
);

    import fetch_pkg::*;

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    // Storage has no reset, so a program can be loaded while the core is held in reset.
    byte_t mem [0:DEPTH-1];

    // Only the low address bits decode.
    // Higher bits are ignored, so addresses wrap around the RAM.
    logic [ADDR_WIDTH-1:0] rd_idx;
    logic [ADDR_WIDTH-1:0] wr_idx;

    assign rd_idx = rd_addr[ADDR_WIDTH-1:0];
    assign wr_idx = wr_addr[ADDR_WIDTH-1:0];

    // Program load write.
    // It takes effect at this edge.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_idx] <= wr_data;
        end
    end

    // Fetch read.
    // The data appears in the cycle after the address.
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_idx];
    end

endmodule

`default_nettype wire

//--- rtl/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

// Instruction fetch subsystem.
// A program counter feeds a byte-serial fetch controller, which reads from a byte RAM.
// The outside world loads programs through the prog_* write port and receives one
// instruction every six cycles on the inst_* outputs.
module fetch_top #(
    parameter int               ADDR_WIDTH = 10,
    parameter fetch_pkg::addr_t RESET_PC   = '0
) (
    input  logic             clk,
    input  logic             rst_n,

    // Jump target from the core.
    // It is used by the next fetch start.
    input  logic             redirect,
    input  fetch_pkg::addr_t redirect_target,

    // Program load port.
    // It works during reset or while fetching runs.
    input  logic             prog_we,
    input  fetch_pkg::addr_t prog_addr,
    input  fetch_pkg::byte_t prog_data,

    // Delivered instruction.
    // inst_valid is a one-cycle pulse with no back-pressure.
    output logic             inst_valid,
    output fetch_pkg::inst_t inst,
    output fetch_pkg::addr_t inst_addr
);

    import fetch_pkg::*;

    // Handshake between the program counter and the controller.
    fetch_if u_fif ();

    // Controller read port into the RAM.
    addr_t ram_addr;
    byte_t ram_rdata;

    pc_reg #(
        .RESET_PC (RESET_PC)
    ) u_pc_reg (
        .clk             (clk),
        .rst_n           (rst_n),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .fif             (u_fif.pc)
    );

    mem_control u_mem_control (
        .clk       (clk),
        .rst_n     (rst_n),
        .ram_addr  (ram_addr),
        .ram_rdata (ram_rdata),
        .fif       (u_fif.ctrl)
    );

    byte_ram #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_byte_ram (
        .clk     (clk),
        .rd_addr (ram_addr),
        .rd_data (ram_rdata),
        .wr_en   (prog_we),
        .wr_addr (prog_addr),
        .wr_data (prog_data)
    );

    // The controller's delivery signals are the subsystem outputs.
    assign inst_valid = u_fif.done;
    assign inst       = u_fif.inst;
    assign inst_addr  = u_fif.inst_addr;

endmodule

`default_nettype wire

//--- sim/tb_fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

// Self-checking testbench for the instruction fetch subsystem.
// A byte model mirrors every program write, and a small tracker follows the fetch address.
module tb_fetch_top;

    import fetch_pkg::*;

    localparam int    ADDR_WIDTH  = 10;
    localparam int    MEM_SIZE    = 2 ** ADDR_WIDTH;
    localparam addr_t RESET_PC    = '0;
    localparam addr_t SPAN_TARGET = 32'h0000_03fe;
    localparam addr_t LIVE_ADDR   = 32'h0000_0100;

    logic  clk;
    logic  rst_n;
    logic  redirect;
    addr_t redirect_target;
    logic  prog_we;
    addr_t prog_addr;
    byte_t prog_data;
    logic  inst_valid;
    inst_t inst;
    addr_t inst_addr;

    // Mirror of the RAM, written at the same edge as the DUT's RAM.
    byte_t model [0:MEM_SIZE-1];

    // Bytes that get rewritten while fetching runs.
    byte_t live_bytes [0:3];

    int errors       = 0;
    int checks       = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    bit aborted      = 1'b0;
    bit load_done    = 1'b0;

    // Tracker state. It follows the address handshake from the outside.
    int    cyc         = 0;
    int    rst_cycles  = 0;
    addr_t next_pc;
    addr_t inflight;
    addr_t pend_target;
    bit    pend        = 1'b0;
    bit    has_flight  = 1'b0;

    fetch_top #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .RESET_PC   (RESET_PC)
    ) u_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .prog_we         (prog_we),
        .prog_addr       (prog_addr),
        .prog_data       (prog_data),
        .inst_valid      (inst_valid),
        .inst            (inst),
        .inst_addr       (inst_addr)
    );

    // 20 ns clock.
    always #10 clk = ~clk;

    // Compare one value and count it.
    task automatic compare_value(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("FAIL %s: got 0x%08h, expected 0x%08h", sig, got, exp);
            errors++;
        end
    endtask

    // Stops further stimulus after a wait ran out of time.
    task automatic flag_timeout(input string what);
        $display("timeout: %s", what);
        errors++;
        aborted = 1'b1;
    endtask

    // Word from the model, lowest address in the top byte, wrapping at the RAM size.
    function automatic inst_t word_at(input addr_t a);
        inst_t w;
        addr_t b;
        int    i;
        w = '0;
        for (i = 0; i < 4; i++) begin
            b = a + addr_t'(i);
            w = {w[23:0], model[b[ADDR_WIDTH-1:0]]};
        end
        return w;
    endfunction

    // Waits for the next inst_valid pulse, at most 20 cycles.
    task automatic wait_valid();
        int n;
        n = 0;
        @(posedge clk);
        while (inst_valid !== 1'b1 && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (inst_valid !== 1'b1) begin
            flag_timeout("inst_valid did not pulse within 20 cycles");
        end
    endtask

    // Waits for the next instruction and checks its address and word.
    task automatic expect_addr(input addr_t exp);
        if (!aborted) begin
            wait_valid();
            if (!aborted) begin
                compare_value("inst_addr", inst_addr, exp);
                compare_value("inst", inst, word_at(exp));
            end
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d mismatches", name, errors - err_before);
        end
    endtask

    // Per-cycle monitor.
    // Pulses are due every sixth edge after reset release, and each start edge captures
    // the tracked fetch address before it moves on.
    always @(posedge clk) begin
        if (!rst_n) begin
            // Outputs are known only after the first reset edge.
            if (rst_cycles > 0) begin
                compare_value("inst_valid", inst_valid, 1'b0);
                compare_value("inst", inst, '0);
                compare_value("inst_addr", inst_addr, '0);
            end
            rst_cycles++;
            cyc        = 0;
            next_pc    = RESET_PC;
            pend       = 1'b0;
            has_flight = 1'b0;
        end else begin
            if (cyc % 6 == 0) begin
                if (has_flight) begin
                    compare_value("inst_valid", inst_valid, 1'b1);
                    compare_value("inst_addr", inst_addr, inflight);
                    compare_value("inst", inst, word_at(inflight));
                end else begin
                    compare_value("inst_valid", inst_valid, 1'b0);
                end
                inflight   = next_pc;
                has_flight = 1'b1;
                // A redirect in the start cycle itself beats an older pending one.
                if (redirect) begin
                    next_pc = redirect_target;
                end else if (pend) begin
                    next_pc = pend_target;
                end else begin
                    next_pc = next_pc + 32'd4;
                end
                pend = 1'b0;
            end else begin
                compare_value("inst_valid", inst_valid, 1'b0);
                if (redirect) begin
                    pend        = 1'b1;
                    pend_target = redirect_target;
                end
            end
            cyc++;
        end
        // The RAM takes the write at this same edge.
        if (prog_we) begin
            model[prog_addr[ADDR_WIDTH-1:0]] = prog_data;
        end
    end

    // Program loader. It starts during reset and stays ahead of the fetch stream,
    // since it writes six bytes in the time the core takes four.
    initial begin : program_loader
        int unsigned seed;
        int          i;
        seed = 32'h8b1c_b9a5;
        void'($urandom(seed));
        for (i = 0; i < MEM_SIZE; i++) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= addr_t'(i);
            prog_data <= byte_t'($urandom);
        end
        for (i = 0; i < 4; i++) begin
            live_bytes[i] = byte_t'($urandom);
        end
        @(posedge clk);
        prog_we   <= 1'b0;
        load_done = 1'b1;
    end

    // Reset is held for 4 cycles, and the first instruction must come from RESET_PC.
    task automatic reset_release();
        int e0;
        e0 = errors;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        wait_valid();
        if (!aborted) begin
            compare_value("inst_addr", inst_addr, RESET_PC);
        end
        report_test("reset", e0);
    endtask

    // Pulses must be one cycle wide and six cycles apart.
    // The task starts on a pulse edge.
    task automatic pulse_timing();
        int e0;
        int k;
        int gap;
        e0 = errors;
        for (k = 0; k < 4 && !aborted; k++) begin
            @(posedge clk);
            gap = 1;
            compare_value("inst_valid", inst_valid, 1'b0);
            while (inst_valid !== 1'b1 && gap < 20) begin
                @(posedge clk);
                gap++;
            end
            if (inst_valid !== 1'b1) begin
                flag_timeout("no second inst_valid pulse within 20 cycles");
            end else begin
                compare_value("inst_valid spacing", gap, 6);
            end
        end
        report_test("pulse timing", e0);
    endtask

    task automatic byte_order();
        int e0;
        int k;
        e0 = errors;
        for (k = 0; k < 8 && !aborted; k++) begin
            wait_valid();
            if (!aborted) begin
                compare_value("inst", inst, word_at(inst_addr));
            end
        end
        report_test("byte order", e0);
    endtask

    task automatic wait_load();
        int n;
        n = 0;
        while (!load_done && n < 2000) begin
            @(posedge clk);
            n++;
        end
        if (!load_done) begin
            flag_timeout("program load did not finish within 2000 cycles");
        end
    endtask

    // Runs past the end of the RAM with no redirect. The address keeps counting
    // while the RAM wraps, so 0x400 returns bytes 0 to 3.
    task automatic sequential_wrap();
        int    e0;
        int    k;
        addr_t exp;
        e0 = errors;
        wait_valid();
        exp = inst_addr;
        for (k = 0; k < 400 && !aborted && exp != addr_t'(MEM_SIZE + 8); k++) begin
            exp = exp + 32'd4;
            expect_addr(exp);
        end
        if (!aborted) begin
            compare_value("inst_addr after wrap", inst_addr, addr_t'(MEM_SIZE + 8));
        end
        report_test("sequential and wrap", e0);
    endtask

    // The address after the pulse is already taken, so two sequential words
    // come out before the redirect target.
    task automatic redirect_flow();
        int    e0;
        addr_t base;
        e0 = errors;
        wait_valid();
        if (!aborted) begin
            base = inst_addr;
            redirect        <= 1'b1;
            redirect_target <= SPAN_TARGET;
            @(posedge clk);
            redirect <= 1'b0;
            expect_addr(base + 32'd4);
            expect_addr(base + 32'd8);
            // This word spans the end of the RAM.
            expect_addr(SPAN_TARGET);
            expect_addr(SPAN_TARGET + 32'd4);
        end
        if (!aborted) begin
            // When two redirects arrive before one start, the second one must win.
            base = inst_addr;
            redirect        <= 1'b1;
            redirect_target <= 32'h0000_0200;
            @(posedge clk);
            redirect <= 1'b0;
            @(posedge clk);
            redirect        <= 1'b1;
            redirect_target <= 32'h0000_02c0;
            @(posedge clk);
            redirect <= 1'b0;
            expect_addr(base + 32'd4);
            expect_addr(base + 32'd8);
            expect_addr(32'h0000_02c0);
        end
        report_test("redirect", e0);
    endtask

    // Rewrites a word that was fetched before, then jumps back to it.
    task automatic live_write();
        int    e0;
        int    i;
        addr_t base;
        inst_t exp_word;
        e0 = errors;
        exp_word = {live_bytes[0], live_bytes[1], live_bytes[2], live_bytes[3]};
        wait_valid();
        if (!aborted) begin
            for (i = 0; i < 4; i++) begin
                prog_we   <= 1'b1;
                prog_addr <= LIVE_ADDR + addr_t'(i);
                prog_data <= live_bytes[i];
                @(posedge clk);
            end
            prog_we <= 1'b0;
            wait_valid();
        end
        if (!aborted) begin
            base = inst_addr;
            redirect        <= 1'b1;
            redirect_target <= LIVE_ADDR;
            @(posedge clk);
            redirect <= 1'b0;
            expect_addr(base + 32'd4);
            expect_addr(base + 32'd8);
            expect_addr(LIVE_ADDR);
            if (!aborted) begin
                compare_value("inst", inst, exp_word);
            end
        end
        report_test("live write", e0);
    endtask

    initial begin
        clk             = 1'b0;
        rst_n           = 1'b0;
        redirect        = 1'b0;
        redirect_target = '0;
        prog_we         = 1'b0;
        prog_addr       = '0;
        prog_data       = '0;

        reset_release();
        if (!aborted) pulse_timing();
        if (!aborted) byte_order();
        if (!aborted) wait_load();
        if (!aborted) sequential_wrap();
        if (!aborted) redirect_flow();
        if (!aborted) live_write();

        $display("summary: %0d tests run, %0d failed, %0d checks, %0d mismatches",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
rtl/fetch_pkg.sv
rtl/fetch_if.sv
rtl/pc_reg.sv
rtl/mem_control.sv
rtl/byte_ram.sv
rtl/fetch_top.sv
sim/tb_fetch_top.sv

//--- Bender.yml
package:
  name: fetch_subsystem

sources:
  # Design sources in compile order.
  - files:
      - rtl/fetch_pkg.sv
      - rtl/fetch_if.sv
      - rtl/pc_reg.sv
      - rtl/mem_control.sv
      - rtl/byte_ram.sv
      - rtl/fetch_top.sv

  # Self-checking testbench with top module tb_fetch_top.
  - target: test
    files:
      - sim/tb_fetch_top.sv
